// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = f2_cpu_glue_tb
FILELIST   = f2_cpu_glue.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/bus_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  f2_pkg::cpu_bus_t      bus,
    input  logic [15:0]           din,
    input  logic                  dtack_n,
    input  logic [2:0]            ipl_n,
    input  f2_pkg::sdr_req_t      sdr_req,
    input  f2_pkg::rgb_t          pixel_rgb,
    input  logic                  check_en,
    input  logic [8*10-1:0]       test_name,
    input  logic                  cmp_din,
    input  logic                  cmp_ipl,
    input  logic                  cmp_pixel,
    input  logic [23:0]           exp_value,
    input  logic                  exp_req,
    input  logic [26:0]           exp_req_addr,
    input  logic [1:0]            exp_req_be,
    output int                    tests_run,
    output int                    errors
);
    import f2_pkg::*;

    logic        req_seen;
    int          req_count;
    int          test_errors;
    logic [26:0] seen_addr;
    logic [1:0]  seen_be;
    logic [15:0] seen_din;

    task automatic compare_value(
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_seen  = 1'b0;
            req_count = 0;
            tests_run = 0;
            errors    = 0;
        end else begin
            if (check_en) begin
                test_errors = 0;
                if (cmp_din) begin
                    compare_value("din", {16'h0000, exp_value[15:0]}, {16'h0000, seen_din});
                end
                if (cmp_ipl) begin
                    compare_value("ipl_n", {29'h0, exp_value[2:0]}, {29'h0, ipl_n});
                end
                if (cmp_pixel) begin
                    compare_value("pixel_rgb", {8'h00, exp_value}, {8'h00, pixel_rgb});
                end
                compare_value("sdram requests", exp_req ? 32'd1 : 32'd0, req_count);
                if (exp_req && req_count > 0) begin
                    compare_value("sdram address", {5'h0, exp_req_addr}, {5'h0, seen_addr});
                    compare_value("byte enables", {30'h0, exp_req_be}, {30'h0, seen_be});
                end
                $display("%s: %s", test_name, test_errors == 0 ? "ok" : "mismatch");
                tests_run++;
                errors    = errors + test_errors;
                req_count = 0;
            end

            // Every toggle is one new SDRAM request
            if (sdr_req.req !== req_seen) begin
                req_seen  = sdr_req.req;
                req_count = req_count + 1;
                seen_addr = sdr_req.addr;
                seen_be   = sdr_req.be;
            end

            if (!(&bus.ds_n) && !dtack_n) begin
                seen_din = din;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/f2_cpu_glue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module f2_cpu_glue_tb;
    import f2_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_TESTS      = 20;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 40 + RESET_CYCLES;

    typedef enum logic [2:0] {K_WRITE, K_READ, K_VBLANK, K_DMA, K_IACK, K_PIXEL} kind_t;

    typedef struct packed {
        logic [8*10-1:0] name;
        kind_t           kind;
        logic [23:0]     addr;
        logic [1:0]      ds_n;
        logic [15:0]     data;
        logic [23:0]     expected;
    } test_row_t;

    logic                  clk;
    logic                  reset;
    cpu_bus_t              bus;
    logic [15:0]           din;
    logic                  dtack_n;
    logic [2:0]            ipl_n;
    sdr_req_t              sdr_req;
    logic                  sdr_ack = 1'b0;
    logic [15:0]           sdr_q = 16'h0000;
    logic                  vblank_n;
    logic                  dma_n;
    player_inputs_t        inputs;
    logic [PALETTE_AW-1:0] pixel_index;
    rgb_t                  pixel_rgb;

    logic                  check_en;
    logic [8*10-1:0]       check_name;
    logic                  cmp_din;
    logic                  cmp_ipl;
    logic                  cmp_pixel;
    logic [23:0]           exp_value;
    logic                  exp_req;
    logic [26:0]           exp_req_addr;
    logic [1:0]            exp_req_be;
    int                    tests_run;
    int                    errors;
    int                    cycle_count = 0;

    test_row_t             rows [NUM_TESTS];
    logic [15:0]           rom_mem  [2**15];
    logic [15:0]           work_mem [2**15];
    logic [31:0]           rng_state;
    int                    latency;

    f2_cpu_glue dut (
        .clk         (clk),
        .reset       (reset),
        .bus         (bus),
        .din         (din),
        .dtack_n     (dtack_n),
        .ipl_n       (ipl_n),
        .sdr_req     (sdr_req),
        .sdr_ack     (sdr_ack),
        .sdr_q       (sdr_q),
        .vblank_n    (vblank_n),
        .dma_n       (dma_n),
        .inputs      (inputs),
        .pixel_index (pixel_index),
        .pixel_rgb   (pixel_rgb)
    );

    bus_checker scoreboard (
        .clk          (clk),
        .reset        (reset),
        .bus          (bus),
        .din          (din),
        .dtack_n      (dtack_n),
        .ipl_n        (ipl_n),
        .sdr_req      (sdr_req),
        .pixel_rgb    (pixel_rgb),
        .check_en     (check_en),
        .test_name    (check_name),
        .cmp_din      (cmp_din),
        .cmp_ipl      (cmp_ipl),
        .cmp_pixel    (cmp_pixel),
        .exp_value    (exp_value),
        .exp_req      (exp_req),
        .exp_req_addr (exp_req_addr),
        .exp_req_be   (exp_req_be),
        .tests_run    (tests_run),
        .errors       (errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a bus cycle never completed", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // SDRAM model

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic serve_request;
        logic [14:0] index;
        index = sdr_req.addr[15:1];
        if (sdr_req.addr >= WORK_RAM_SDR_BASE) begin
            if (sdr_req.rw) begin
                sdr_q <= work_mem[index];
            end else begin
                if (sdr_req.be[1]) begin
                    work_mem[index][15:8] = sdr_req.data[15:8];
                end
                if (sdr_req.be[0]) begin
                    work_mem[index][7:0] = sdr_req.data[7:0];
                end
            end
        end else begin
            sdr_q <= rom_mem[index];
        end
        sdr_ack <= sdr_req.req;
    endtask

    initial begin
        rng_state = 32'd7;
        latency   = 0;
        for (int i = 0; i < 2**15; i++) begin
            rom_mem[i]  = {i[14:0], 1'b0} ^ 16'hA5A5;
            work_mem[i] = {1'b0, i[14:0]};
        end
    end

    // Answer each toggle after 1 to 6 cycles
    always @(posedge clk) begin
        if (reset) begin
            latency = 0;
        end else if (latency != 0) begin
            latency = latency - 1;
            if (latency == 0) begin
                serve_request();
            end
        end else if (sdr_req.req != sdr_ack) begin
            rng_state = xorshift32(rng_state);
            latency   = 1 + int'(rng_state % 32'd6);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic load_table;
        rows[0]  = '{"io_dswa",   K_READ,   24'h300000, 2'b00, 16'h0000, 24'h0000C3};
        rows[1]  = '{"io_dswb",   K_READ,   24'h300002, 2'b00, 16'h0000, 24'h00007E};
        rows[2]  = '{"io_p1",     K_READ,   24'h300004, 2'b00, 16'h0000, 24'h000065};
        rows[3]  = '{"io_p2",     K_READ,   24'h300006, 2'b00, 16'h0000, 24'h00009A};
        rows[4]  = '{"io_coin",   K_READ,   24'h300008, 2'b00, 16'h0000, 24'h0000F7};
        rows[5]  = '{"io_spare",  K_READ,   24'h30000A, 2'b00, 16'h0000, 24'h0000FF};
        rows[6]  = '{"rom_word",  K_READ,   24'h001234, 2'b00, 16'h0000, 24'h00B791};
        rows[7]  = '{"rom_upper", K_READ,   24'h00ABCE, 2'b01, 16'h0000, 24'h000E6B};
        rows[8]  = '{"rom_top",   K_READ,   24'h00FFFE, 2'b00, 16'h0000, 24'h005A5B};
        rows[9]  = '{"work_wr_w", K_WRITE,  24'h100040, 2'b00, 16'h1234, 24'h000000};
        rows[10] = '{"work_wr_b", K_WRITE,  24'h100040, 2'b10, 16'hEEAB, 24'h000000};
        rows[11] = '{"work_rd",   K_READ,   24'h100040, 2'b00, 16'h0000, 24'h0012AB};
        rows[12] = '{"pal_wr",    K_WRITE,  24'h200010, 2'b00, 16'h65B6, 24'h000000};
        rows[13] = '{"pal_rd",    K_READ,   24'h200010, 2'b00, 16'h0000, 24'h0065B6};
        rows[14] = '{"pal_pixel", K_PIXEL,  24'h000008, 2'b11, 16'h0000, 24'hB56BCE};
        rows[15] = '{"vbl_edge",  K_VBLANK, 24'h000000, 2'b11, 16'h0000, 24'h000002};
        rows[16] = '{"dma_edge",  K_DMA,    24'h000000, 2'b11, 16'h0001, 24'h000001};
        rows[17] = '{"iack_6",    K_IACK,   24'hFFFFFC, 2'b00, 16'h0000, 24'h000002};
        rows[18] = '{"iack_5",    K_IACK,   24'hFFFFFA, 2'b00, 16'h0000, 24'h000007};
        rows[19] = '{"unmapped",  K_READ,   24'h400000, 2'b00, 16'h0000, 24'h000000};
    endtask

    // Holds the cycle until DTACK, then drops the strobes
    task automatic bus_cycle(input test_row_t row);
        @(posedge clk);
        bus <= '{word_addr: row.addr, ds_n: row.ds_n, rw: row.kind != K_WRITE,
                 fc: (row.kind == K_IACK) ? 3'b111 : 3'b101, dout: row.data};
        do begin
            @(posedge clk);
        end while (dtack_n !== 1'b0);
        bus.ds_n <= 2'b11;
    endtask

    task automatic run_row(input test_row_t row);
        logic        req_expected;
        logic [26:0] req_addr;
        case (row.kind)
            K_VBLANK: begin
                @(posedge clk);
                vblank_n <= row.data[0];
                @(posedge clk);
            end
            K_DMA: begin
                @(posedge clk);
                dma_n <= row.data[0];
                @(posedge clk);
            end
            K_PIXEL: begin
                @(posedge clk);
                pixel_index <= row.addr[PALETTE_AW-1:0];
                @(posedge clk);
            end
            default: bus_cycle(row);
        endcase

        // SDRAM traffic expected from the memory map
        req_expected = 1'b0;
        req_addr     = '0;
        if (row.kind == K_READ || row.kind == K_WRITE) begin
            if ((row.addr & ROM_MASK) == ROM_BASE) begin
                req_expected = 1'b1;
                req_addr     = CPU_ROM_SDR_BASE + {3'b000, row.addr};
            end else if ((row.addr & WORK_MASK) == WORK_BASE) begin
                req_expected = 1'b1;
                req_addr     = WORK_RAM_SDR_BASE + {11'h000, row.addr[15:0]};
            end
        end

        check_en     <= 1'b1;
        check_name   <= row.name;
        cmp_din      <= row.kind == K_READ;
        cmp_ipl      <= row.kind inside {K_VBLANK, K_DMA, K_IACK};
        cmp_pixel    <= row.kind == K_PIXEL;
        exp_value    <= row.expected;
        exp_req      <= req_expected;
        exp_req_addr <= req_addr;
        exp_req_be   <= ~row.ds_n;
        @(posedge clk);
        check_en <= 1'b0;
    endtask

    initial begin
        bus          = '{word_addr: 24'h000000, ds_n: 2'b11, rw: 1'b1, fc: 3'b000, dout: 16'h0000};
        reset        = 1'b1;
        vblank_n     = 1'b1;
        dma_n        = 1'b0;
        pixel_index  = '0;
        inputs       = '{joy_p1: 8'h15, joy_p2: 8'h6A, start: 2'b01, coin: 2'b10,
                         dswa: 8'h3C, dswb: 8'h81};
        check_en     = 1'b0;
        check_name   = '0;
        cmp_din      = 1'b0;
        cmp_ipl      = 1'b0;
        cmp_pixel    = 1'b0;
        exp_value    = '0;
        exp_req      = 1'b0;
        exp_req_addr = '0;
        exp_req_be   = '0;
        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(rows[i]);
        end
        repeat (2) @(posedge clk);

        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0 && tests_run == NUM_TESTS) begin
            $display("Verification passed");
        end else begin
            if (tests_run != NUM_TESTS) begin
                $display("Only %0d of %0d tests were checked", tests_run, NUM_TESTS);
            end
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== f2_cpu_glue.f ====
source/f2_pkg.sv
source/address_decoder.sv
source/sdram_bridge.sv
source/interrupt_controller.sv
source/input_ports.sv
source/palette_ram.sv
source/f2_cpu_glue.sv
bench/bus_checker.sv
bench/f2_cpu_glue_tb.sv

// ==== source/address_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module address_decoder (
    input  f2_pkg::cpu_bus_t  bus,
    output f2_pkg::chip_sel_t sel
);
    import f2_pkg::*;

    logic strobe;

    function automatic logic region_hit(
        input logic [23:0] addr,
        input logic [23:0] base,
        input logic [23:0] mask
    );
        return (addr & mask) == base;
    endfunction

    assign strobe = ~&bus.ds_n;

    always_comb begin
        sel = '0;
        if (strobe) begin
            // FC 7 marks an interrupt acknowledge cycle
            if (bus.fc == 3'b111) begin
                sel.iack = 1'b1;
            end else if (region_hit(bus.word_addr, ROM_BASE, ROM_MASK)) begin
                sel.rom = 1'b1;
            end else if (region_hit(bus.word_addr, WORK_BASE, WORK_MASK)) begin
                sel.work = 1'b1;
            end else if (region_hit(bus.word_addr, COLOR_BASE, COLOR_MASK)) begin
                sel.color = 1'b1;
            end else if (region_hit(bus.word_addr, IO_BASE, IO_MASK)) begin
                sel.io = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/f2_cpu_glue.sv ====
`timescale 1ns/1ns
`default_nettype none

module f2_cpu_glue (
    input  logic                          clk,
    input  logic                          reset,
    input  f2_pkg::cpu_bus_t              bus,
    output logic [15:0]                   din,
    output logic                          dtack_n,
    output logic [2:0]                    ipl_n,
    output f2_pkg::sdr_req_t              sdr_req,
    input  logic                          sdr_ack,
    input  logic [15:0]                   sdr_q,
    input  logic                          vblank_n,
    input  logic                          dma_n,
    input  f2_pkg::player_inputs_t        inputs,
    input  logic [f2_pkg::PALETTE_AW-1:0] pixel_index,
    output f2_pkg::rgb_t                  pixel_rgb
);
    import f2_pkg::*;

    chip_sel_t   sel;
    logic        sdr_wait_n;
    logic        color_ready;
    logic        wait_n;
    logic        strobe;
    logic [7:0]  io_rdata;
    logic [15:0] color_rdata;

    assign strobe = ~&bus.ds_n;

    //////////////////////////////////////////////////////////////////////
    // Blocks

    address_decoder u_decoder (
        .bus (bus),
        .sel (sel)
    );

    sdram_bridge u_sdram (
        .clk     (clk),
        .reset   (reset),
        .bus     (bus),
        .sel     (sel),
        .sdr_ack (sdr_ack),
        .sdr_req (sdr_req),
        .wait_n  (sdr_wait_n)
    );

    interrupt_controller u_irq (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .sel      (sel),
        .vblank_n (vblank_n),
        .dma_n    (dma_n),
        .ipl_n    (ipl_n)
    );

    input_ports u_io (
        .bus    (bus),
        .sel    (sel),
        .inputs (inputs),
        .rdata  (io_rdata)
    );

    palette_ram u_palette (
        .clk         (clk),
        .bus         (bus),
        .sel         (sel),
        .pixel_index (pixel_index),
        .cpu_rdata   (color_rdata),
        .pixel_rgb   (pixel_rgb)
    );

    //////////////////////////////////////////////////////////////////////
    // Read data and DTACK

    // Palette read data needs one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            color_ready <= 1'b0;
        end else begin
            color_ready <= sel.color;
        end
    end

    assign wait_n = sdr_wait_n & (~sel.color | color_ready);

    always_comb begin
        if (sel.rom || sel.work) begin
            din = sdr_q;
        end else if (sel.color) begin
            din = color_rdata;
        end else if (sel.io) begin
            din = {8'h00, io_rdata};
        end else begin
            din = 16'h0000;
        end
    end

    assign dtack_n = strobe ? ~wait_n : 1'b1;

endmodule

`default_nettype wire

// ==== source/f2_pkg.sv ====
`default_nettype none

package f2_pkg;

    //////////////////////////////////////////////////////////////////////
    // Memory map in 68000 byte addresses

    localparam logic [23:0] ROM_BASE   = 24'h000000;
    localparam logic [23:0] ROM_MASK   = 24'hF00000;
    localparam logic [23:0] WORK_BASE  = 24'h100000;
    localparam logic [23:0] WORK_MASK  = 24'hFF0000;
    localparam logic [23:0] COLOR_BASE = 24'h200000;
    localparam logic [23:0] COLOR_MASK = 24'hFFE000;
    localparam logic [23:0] IO_BASE    = 24'h300000;
    localparam logic [23:0] IO_MASK    = 24'hFFFFE0;

    // SDRAM placement
    localparam logic [26:0] CPU_ROM_SDR_BASE  = 27'h0000000;
    localparam logic [26:0] WORK_RAM_SDR_BASE = 27'h0100000;

    // Interrupt levels
    localparam logic [2:0] IPL_VBLANK = 3'd5;
    localparam logic [2:0] IPL_DMA    = 3'd6;

    localparam int PALETTE_AW = 12;

    //////////////////////////////////////////////////////////////////////
    // Shared types

    typedef struct packed {
        logic [23:0] word_addr;
        logic [1:0]  ds_n;      // UDS, LDS
        logic        rw;
        logic [2:0]  fc;
        logic [15:0] dout;
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic work;
        logic color;
        logic io;
        logic iack;
    } chip_sel_t;

    typedef struct packed {
        logic [26:0] addr;
        logic [15:0] data;
        logic [1:0]  be;
        logic        rw;        // 1 is read
        logic        req;
    } sdr_req_t;

    typedef struct packed {
        logic [7:0] joy_p1;
        logic [7:0] joy_p2;
        logic [1:0] start;
        logic [1:0] coin;
        logic [7:0] dswa;
        logic [7:0] dswb;
    } player_inputs_t;

    // xBGR555 as stored by the CPU
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic       unused;
            logic [4:0] blue;
            logic [4:0] green;
            logic [4:0] red;
        } color;
    } palette_word_u;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

`default_nettype wire

// ==== source/input_ports.sv ====
`timescale 1ns/1ns
`default_nettype none

module input_ports (
    input  f2_pkg::cpu_bus_t       bus,
    input  f2_pkg::chip_sel_t      sel,
    input  f2_pkg::player_inputs_t inputs,
    output logic [7:0]             rdata
);

    logic [3:0] index;
    logic [7:0] p1_wire;
    logic [7:0] p2_wire;

    // Board wire order from bit 7 is start, buttons 3..1, right, left, down, up
    function automatic logic [7:0] wire_order(
        input logic [7:0] joy,
        input logic       start
    );
        return {start, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    assign index   = bus.word_addr[4:1];
    assign p1_wire = wire_order(inputs.joy_p1, inputs.start[0]);
    assign p2_wire = wire_order(inputs.joy_p2, inputs.start[1]);

    always_comb begin
        rdata = 8'hFF;
        if (sel.io) begin
            case (index)
                4'd0: rdata = ~inputs.dswa;
                4'd1: rdata = ~inputs.dswb;
                4'd2: rdata = ~p1_wire;
                4'd3: rdata = ~p2_wire;
                4'd4: rdata = {4'b1111, ~inputs.coin, 2'b11};
                default: rdata = 8'hFF;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/interrupt_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module interrupt_controller (
    input  logic              clk,
    input  logic              reset,
    input  f2_pkg::cpu_bus_t  bus,
    input  f2_pkg::chip_sel_t sel,
    input  logic              vblank_n,
    input  logic              dma_n,
    output logic [2:0]        ipl_n
);
    import f2_pkg::*;

    logic vblank_prev;
    logic dma_prev;
    logic vblank_pend;
    logic dma_pend;
    logic vblank_edge;
    logic dma_edge;
    logic ack_vblank;
    logic ack_dma;

    assign vblank_edge = vblank_prev & ~vblank_n;
    assign dma_edge    = ~dma_prev & dma_n;

    // A3..A1 carry the level being acknowledged
    assign ack_vblank = sel.iack & (bus.word_addr[3:1] == IPL_VBLANK);
    assign ack_dma    = sel.iack & (bus.word_addr[3:1] == IPL_DMA);

    // Pin levels from the previous clock
    always_ff @(posedge clk) begin
        vblank_prev <= vblank_n;
        dma_prev    <= dma_n;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vblank_pend <= 1'b0;
            dma_pend    <= 1'b0;
        end else begin
            if (vblank_edge) begin
                vblank_pend <= 1'b1;
            end
            if (dma_edge) begin
                dma_pend <= 1'b1;
            end
            if (ack_vblank) begin
                vblank_pend <= 1'b0;
            end
            if (ack_dma) begin
                dma_pend <= 1'b0;
            end
        end
    end

    // Highest pending level wins
    assign ipl_n = dma_pend    ? ~IPL_DMA :
                   vblank_pend ? ~IPL_VBLANK :
                   3'b111;

endmodule

`default_nettype wire

// ==== source/palette_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module palette_ram (
    input  logic                          clk,
    input  f2_pkg::cpu_bus_t              bus,
    input  f2_pkg::chip_sel_t             sel,
    input  logic [f2_pkg::PALETTE_AW-1:0] pixel_index,
    output logic [15:0]                   cpu_rdata,
    output f2_pkg::rgb_t                  pixel_rgb
);
    import f2_pkg::*;

    palette_word_u             mem [2**PALETTE_AW];
    palette_word_u             pix_q;
    logic [PALETTE_AW-1:0]     cpu_addr;
    logic                      cpu_write;

    assign cpu_addr  = bus.word_addr[PALETTE_AW:1];
    assign cpu_write = sel.color & ~bus.rw;

    //////////////////////////////////////////////////////////////////////
    // CPU port

    always_ff @(posedge clk) begin
        if (cpu_write && !bus.ds_n[1]) begin
            mem[cpu_addr].raw[15:8] <= bus.dout[15:8];
        end
        if (cpu_write && !bus.ds_n[0]) begin
            mem[cpu_addr].raw[7:0] <= bus.dout[7:0];
        end
        cpu_rdata <= mem[cpu_addr].raw;
    end

    //////////////////////////////////////////////////////////////////////
    // Pixel port

    always_ff @(posedge clk) begin
        pix_q <= mem[pixel_index];
    end

    // 5 to 8 bits by repeating the top of each channel
    assign pixel_rgb.red   = {pix_q.color.red,   pix_q.color.red[4:2]};
    assign pixel_rgb.green = {pix_q.color.green, pix_q.color.green[4:2]};
    assign pixel_rgb.blue  = {pix_q.color.blue,  pix_q.color.blue[4:2]};

endmodule

`default_nettype wire

// ==== source/sdram_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module sdram_bridge (
    input  logic              clk,
    input  logic              reset,
    input  f2_pkg::cpu_bus_t  bus,
    input  f2_pkg::chip_sel_t sel,
    input  logic              sdr_ack,
    output f2_pkg::sdr_req_t  sdr_req,
    output logic              wait_n
);
    import f2_pkg::*;

    logic        strobe;
    logic        prev_idle;
    logic        new_cycle;
    logic        start;
    logic        req_q;
    logic [26:0] addr_q;
    logic [15:0] data_q;
    logic [1:0]  be_q;
    logic        rw_q;

    assign strobe    = ~&bus.ds_n;
    assign new_cycle = strobe & prev_idle;
    assign start     = new_cycle & (sel.rom | sel.work);

    //////////////////////////////////////////////////////////////////////
    // Toggle side

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_idle <= 1'b1;
            req_q     <= 1'b0;
        end else begin
            prev_idle <= ~strobe;
            if (start) begin
                req_q <= ~req_q;
            end
        end
    end

    // Request payload latched with the toggle
    always_ff @(posedge clk) begin
        if (new_cycle && sel.rom) begin
            addr_q <= CPU_ROM_SDR_BASE + {3'b0, bus.word_addr};
            be_q   <= ~bus.ds_n;
            rw_q   <= 1'b1;
        end else if (new_cycle && sel.work) begin
            addr_q <= WORK_RAM_SDR_BASE + {11'b0, bus.word_addr[15:0]};
            data_q <= bus.dout;
            be_q   <= ~bus.ds_n;
            rw_q   <= bus.rw;
        end
    end

    assign sdr_req = '{addr: addr_q, data: data_q, be: be_q, rw: rw_q, req: req_q};

    // Held off from the first strobe cycle until the ack catches up
    assign wait_n = ~(start | (req_q != sdr_ack));

endmodule

`default_nettype wire
